// ==== logic/blu_isa_pkg.sv ====
// Branch ISA definitions
package blu_isa_pkg;

	localparam int XLEN = 64;
	localparam int OP_W = 8;

	// Register values, pc, immediate and target
	typedef logic [XLEN-1:0] xlen_t;

	// One-hot branch operation
	typedef logic [OP_W-1:0] blu_op_t;

	localparam blu_op_t OP_JAL  = 8'b1000_0000;
	localparam blu_op_t OP_JALR = 8'b0100_0000;
	localparam blu_op_t OP_BEQ  = 8'b0010_0000;
	localparam blu_op_t OP_BNE  = 8'b0001_0000;
	localparam blu_op_t OP_BLT  = 8'b0000_1000;
	localparam blu_op_t OP_BGE  = 8'b0000_0100;
	localparam blu_op_t OP_BLTU = 8'b0000_0010;
	localparam blu_op_t OP_BGEU = 8'b0000_0001;

	// Fixed 32-bit encoding, no compressed instructions
	localparam xlen_t INSN_BYTES = 4;

endpackage

// ==== logic/blu_cfg_pkg.sv ====
// Branch unit sizing
package blu_cfg_pkg;

	localparam int BLU_ISSUE_DEPTH = 8;
	localparam int PREG_NUM = 64;
	localparam int PREG_W = $clog2(PREG_NUM);

	// Physical register index, 0 is the zero register
	typedef logic [PREG_W-1:0] preg_t;

	// op, pc, imm, rd, rs1, rs2
	localparam int BLU_ENTRY_W = $bits(blu_isa_pkg::blu_op_t)
		+ 2 * $bits(blu_isa_pkg::xlen_t)
		+ 3 * PREG_W;

endpackage

// ==== logic/gen_buffer.sv ====
// Generic synchronous FIFO
`timescale 1ns/1ps

module gen_buffer #(
	parameter int DP = 8,
	parameter int DW = 32
) (
	input  logic          CLK,
	input  logic          rst_n,

	input  logic          valid_a,
	output logic          ready_a,
	input  logic [DW-1:0] data_a,

	output logic          valid_b,
	input  logic          ready_b,
	output logic [DW-1:0] data_b
);

	localparam int AW = (DP > 1) ? $clog2(DP) : 1;
	localparam int CW = $clog2(DP + 1);

	logic [DW-1:0] mem [DP];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push;
	logic          pop;

	assign ready_a = (count != CW'(DP));
	assign valid_b = (count != '0);
	assign data_b  = mem[rd_ptr]; // Head shown without a read cycle

	assign push = valid_a && ready_a;
	assign pop  = valid_b && ready_b;

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= data_a;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DP - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DP - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Occupancy within depth, a full buffer has its pointers met
	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
		(count <= CW'(DP)) && (count != CW'(DP) || wr_ptr == rd_ptr));

	// Empty buffer has its pointers met, nothing left behind to pop
	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n)
		(count == '0) |-> (wr_ptr == rd_ptr));

endmodule

// ==== logic/blu_issue.sv ====
// Branch issue queue
`timescale 1ns/1ps

module blu_issue (
	input  logic                    CLK,
	input  logic                    rst_n,

	input  logic                    dispatch_valid,
	output logic                    dispatch_ready,
	input  blu_isa_pkg::blu_op_t    dispatch_op,
	input  blu_isa_pkg::xlen_t      dispatch_pc,
	input  blu_isa_pkg::xlen_t      dispatch_imm,
	input  blu_cfg_pkg::preg_t      dispatch_rd,
	input  blu_cfg_pkg::preg_t      dispatch_rs1,
	input  blu_cfg_pkg::preg_t      dispatch_rs2,

	output logic                    busy_valid,
	output blu_cfg_pkg::preg_t      busy_rd,

	output blu_cfg_pkg::preg_t      rs1,
	output blu_cfg_pkg::preg_t      rs2,
	input  blu_isa_pkg::xlen_t      rs1_data,
	input  blu_isa_pkg::xlen_t      rs2_data,
	input  logic                    rs1_ready,
	input  logic                    rs2_ready,

	output logic                    issue_valid,
	output blu_isa_pkg::blu_op_t    issue_op,
	output blu_isa_pkg::xlen_t      issue_pc,
	output blu_isa_pkg::xlen_t      issue_imm,
	output blu_isa_pkg::xlen_t      issue_src1,
	output blu_isa_pkg::xlen_t      issue_src2,
	output blu_cfg_pkg::preg_t      issue_rd
);

	logic [blu_cfg_pkg::BLU_ENTRY_W-1:0] entry_in;
	logic [blu_cfg_pkg::BLU_ENTRY_W-1:0] entry_head;
	logic                                head_valid;
	logic                                clear_raw;

	blu_isa_pkg::blu_op_t head_op;
	blu_isa_pkg::xlen_t   head_pc;
	blu_isa_pkg::xlen_t   head_imm;
	blu_cfg_pkg::preg_t   head_rd;
	blu_cfg_pkg::preg_t   head_rs1;
	blu_cfg_pkg::preg_t   head_rs2;

	assign entry_in = {
		dispatch_op,
		dispatch_pc,
		dispatch_imm,
		dispatch_rd,
		dispatch_rs1,
		dispatch_rs2
	};

	gen_buffer #(
		.DP(blu_cfg_pkg::BLU_ISSUE_DEPTH),
		.DW(blu_cfg_pkg::BLU_ENTRY_W)
	) i_issue_buffer (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.valid_a (dispatch_valid),
		.ready_a (dispatch_ready),
		.data_a  (entry_in),
		.valid_b (head_valid),
		.ready_b (clear_raw),
		.data_b  (entry_head)
	);

	assign {head_op, head_pc, head_imm, head_rd, head_rs1, head_rs2} = entry_head;

	// New destination goes busy as it enters the queue
	assign busy_valid = dispatch_valid && dispatch_ready;
	assign busy_rd    = dispatch_rd;

	assign rs1 = head_rs1;
	assign rs2 = head_rs2;

	// RAW clear, both sources written
	assign clear_raw = head_valid && rs1_ready && rs2_ready;

	assign issue_valid = clear_raw;
	assign issue_op    = head_op;
	assign issue_pc    = head_pc;
	assign issue_imm   = head_imm;
	assign issue_src1  = rs1_data;
	assign issue_src2  = rs2_data;
	assign issue_rd    = head_rd;

	// Resolver decodes by one-hot select, other codes would drop silently
	a_op_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		(dispatch_valid && dispatch_ready) |-> $onehot(dispatch_op));

endmodule

// ==== logic/reg_scoreboard.sv ====
// Physical register file and scoreboard
`timescale 1ns/1ps

module reg_scoreboard (
	input  logic                 CLK,
	input  logic                 rst_n,

	input  logic                 busy_valid,
	input  blu_cfg_pkg::preg_t   busy_rd,

	input  blu_cfg_pkg::preg_t   rs1,
	input  blu_cfg_pkg::preg_t   rs2,
	output blu_isa_pkg::xlen_t   rs1_data,
	output blu_isa_pkg::xlen_t   rs2_data,
	output logic                 rs1_ready,
	output logic                 rs2_ready,

	input  logic                 wb_valid,
	input  blu_cfg_pkg::preg_t   wb_rd,
	input  blu_isa_pkg::xlen_t   wb_data,

	input  logic                 link_valid,
	input  blu_cfg_pkg::preg_t   link_rd,
	input  blu_isa_pkg::xlen_t   link_data
);

	blu_isa_pkg::xlen_t              regs [blu_cfg_pkg::PREG_NUM];
	logic [blu_cfg_pkg::PREG_NUM-1:0] ready;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ready <= '1;
			for (int i = 0; i < blu_cfg_pkg::PREG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (busy_valid && busy_rd != '0) begin
				ready[busy_rd] <= 1'b0;
			end
			if (wb_valid && wb_rd != '0) begin
				regs[wb_rd]  <= wb_data;
				ready[wb_rd] <= 1'b1;
			end
			if (link_valid && link_rd != '0) begin
				regs[link_rd]  <= link_data;
				ready[link_rd] <= 1'b1; // Link value from jal/jalr
			end
		end
	end

	assign rs1_data  = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data  = (rs2 == '0) ? '0 : regs[rs2];
	assign rs1_ready = (rs1 == '0) || ready[rs1];
	assign rs2_ready = (rs2 == '0) || ready[rs2];

	// One producer per register, external unit and branch link never collide
	a_single_writer: assert property (@(posedge CLK) disable iff (!rst_n)
		(wb_valid && link_valid && wb_rd != '0) |-> (wb_rd != link_rd));

endmodule

// ==== logic/branch_resolve.sv ====
// Branch resolver
`timescale 1ns/1ps

module branch_resolve (
	input  logic                   CLK,
	input  logic                   rst_n,

	input  logic                   issue_valid,
	input  blu_isa_pkg::blu_op_t   issue_op,
	input  blu_isa_pkg::xlen_t     issue_pc,
	input  blu_isa_pkg::xlen_t     issue_imm,
	input  blu_isa_pkg::xlen_t     issue_src1,
	input  blu_isa_pkg::xlen_t     issue_src2,
	input  blu_cfg_pkg::preg_t     issue_rd,

	output logic                   res_valid,
	output blu_isa_pkg::xlen_t     res_pc,
	output logic                   res_taken,
	output blu_isa_pkg::xlen_t     res_target,

	output logic                   link_valid,
	output blu_cfg_pkg::preg_t     link_rd,
	output blu_isa_pkg::xlen_t     link_data
);

	logic                 cmp_eq;
	logic                 cmp_lt;
	logic                 cmp_ltu;
	logic                 is_jalr;
	logic                 is_jump;
	logic                 taken;
	blu_isa_pkg::blu_op_t cond_hit;
	blu_isa_pkg::xlen_t   seq_pc;
	blu_isa_pkg::xlen_t   pc_target;
	blu_isa_pkg::xlen_t   reg_target;
	blu_isa_pkg::xlen_t   target;

	assign cmp_eq  = (issue_src1 == issue_src2);
	assign cmp_lt  = ($signed(issue_src1) < $signed(issue_src2));
	assign cmp_ltu = (issue_src1 < issue_src2);

	// Bits of the operations whose condition holds
	assign cond_hit = blu_isa_pkg::OP_JAL
		| blu_isa_pkg::OP_JALR
		| ({8{cmp_eq}}   & blu_isa_pkg::OP_BEQ)
		| ({8{!cmp_eq}}  & blu_isa_pkg::OP_BNE)
		| ({8{cmp_lt}}   & blu_isa_pkg::OP_BLT)
		| ({8{!cmp_lt}}  & blu_isa_pkg::OP_BGE)
		| ({8{cmp_ltu}}  & blu_isa_pkg::OP_BLTU)
		| ({8{!cmp_ltu}} & blu_isa_pkg::OP_BGEU);

	assign taken   = |(issue_op & cond_hit);
	assign is_jalr = |(issue_op & blu_isa_pkg::OP_JALR);
	assign is_jump = |(issue_op & (blu_isa_pkg::OP_JAL | blu_isa_pkg::OP_JALR));

	assign seq_pc     = issue_pc + blu_isa_pkg::INSN_BYTES;
	assign pc_target  = issue_pc + issue_imm;
	assign reg_target = (issue_src1 + issue_imm) & ~blu_isa_pkg::xlen_t'(1); // jalr clears bit 0
	assign target     = !taken ? seq_pc : (is_jalr ? reg_target : pc_target);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			res_valid  <= 1'b0;
			link_valid <= 1'b0;
		end else begin
			res_valid  <= issue_valid;
			link_valid <= issue_valid && is_jump;
		end
	end

	always_ff @(posedge CLK) begin
		res_pc     <= issue_pc;
		res_taken  <= taken;
		res_target <= target;
		link_rd    <= issue_rd;
		link_data  <= seq_pc; // Return address
	end

endmodule

// ==== logic/blu_top.sv ====
// Branch unit top
`timescale 1ns/1ps

module blu_top (
	input  logic                   CLK,
	input  logic                   rst_n,

	input  logic                   dispatch_valid,
	output logic                   dispatch_ready,
	input  blu_isa_pkg::blu_op_t   dispatch_op,
	input  blu_isa_pkg::xlen_t     dispatch_pc,
	input  blu_isa_pkg::xlen_t     dispatch_imm,
	input  blu_cfg_pkg::preg_t     dispatch_rd,
	input  blu_cfg_pkg::preg_t     dispatch_rs1,
	input  blu_cfg_pkg::preg_t     dispatch_rs2,

	input  logic                   wb_valid,
	input  blu_cfg_pkg::preg_t     wb_rd,
	input  blu_isa_pkg::xlen_t     wb_data,

	output logic                   res_valid,
	output blu_isa_pkg::xlen_t     res_pc,
	output logic                   res_taken,
	output blu_isa_pkg::xlen_t     res_target
);

	logic                 busy_valid;
	blu_cfg_pkg::preg_t   busy_rd;
	blu_cfg_pkg::preg_t   rs1;
	blu_cfg_pkg::preg_t   rs2;
	blu_isa_pkg::xlen_t   rs1_data;
	blu_isa_pkg::xlen_t   rs2_data;
	logic                 rs1_ready;
	logic                 rs2_ready;

	logic                 issue_valid;
	blu_isa_pkg::blu_op_t issue_op;
	blu_isa_pkg::xlen_t   issue_pc;
	blu_isa_pkg::xlen_t   issue_imm;
	blu_isa_pkg::xlen_t   issue_src1;
	blu_isa_pkg::xlen_t   issue_src2;
	blu_cfg_pkg::preg_t   issue_rd;

	logic                 link_valid;
	blu_cfg_pkg::preg_t   link_rd;
	blu_isa_pkg::xlen_t   link_data;

	blu_issue i_issue (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_op    (dispatch_op),
		.dispatch_pc    (dispatch_pc),
		.dispatch_imm   (dispatch_imm),
		.dispatch_rd    (dispatch_rd),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_rs2   (dispatch_rs2),
		.busy_valid     (busy_valid),
		.busy_rd        (busy_rd),
		.rs1            (rs1),
		.rs2            (rs2),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.issue_pc       (issue_pc),
		.issue_imm      (issue_imm),
		.issue_src1     (issue_src1),
		.issue_src2     (issue_src2),
		.issue_rd       (issue_rd)
	);

	reg_scoreboard i_scoreboard (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.busy_valid (busy_valid),
		.busy_rd    (busy_rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.rs1_ready  (rs1_ready),
		.rs2_ready  (rs2_ready),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.link_valid (link_valid),
		.link_rd    (link_rd),
		.link_data  (link_data)
	);

	branch_resolve i_resolve (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_pc    (issue_pc),
		.issue_imm   (issue_imm),
		.issue_src1  (issue_src1),
		.issue_src2  (issue_src2),
		.issue_rd    (issue_rd),
		.res_valid   (res_valid),
		.res_pc      (res_pc),
		.res_taken   (res_taken),
		.res_target  (res_target),
		.link_valid  (link_valid),
		.link_rd     (link_rd),
		.link_data   (link_data)
	);

endmodule

// ==== testbench/tb_clock.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock #(
	parameter realtime PERIOD = 10ns
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
	end

	always begin
		#(PERIOD / 2);
		CLK = ~CLK; // 10 ns period
	end

endmodule

// ==== testbench/blu_tb.sv ====
// Branch unit testbench
`timescale 1ns/1ps

module blu_tb;

	localparam int ROW_WR = 0;
	localparam int ROW_DISP = 1;
	localparam int ROW_FULL = 2; // Dispatch attempt that must be held off
	localparam int MAX_ROWS = 64;

	logic CLK;
	logic rst_n;
	logic dispatch_valid;
	logic dispatch_ready;
	blu_isa_pkg::blu_op_t dispatch_op;
	blu_isa_pkg::xlen_t dispatch_pc;
	blu_isa_pkg::xlen_t dispatch_imm;
	blu_cfg_pkg::preg_t dispatch_rd;
	blu_cfg_pkg::preg_t dispatch_rs1;
	blu_cfg_pkg::preg_t dispatch_rs2;
	logic wb_valid;
	blu_cfg_pkg::preg_t wb_rd;
	blu_isa_pkg::xlen_t wb_data;
	logic res_valid;
	blu_isa_pkg::xlen_t res_pc;
	logic res_taken;
	blu_isa_pkg::xlen_t res_target;

	int row_kind [MAX_ROWS];
	blu_isa_pkg::blu_op_t row_op [MAX_ROWS];
	blu_isa_pkg::xlen_t row_pc [MAX_ROWS];
	blu_isa_pkg::xlen_t row_imm [MAX_ROWS];
	blu_cfg_pkg::preg_t row_rd [MAX_ROWS];
	blu_cfg_pkg::preg_t row_rs1 [MAX_ROWS];
	blu_cfg_pkg::preg_t row_rs2 [MAX_ROWS];
	blu_isa_pkg::xlen_t row_data [MAX_ROWS];
	logic row_taken [MAX_ROWS];
	blu_isa_pkg::xlen_t row_target [MAX_ROWS];
	int row_count = 0;

	blu_isa_pkg::xlen_t model_reg [blu_cfg_pkg::PREG_NUM]; // Value each source holds at issue
	blu_isa_pkg::xlen_t exp_pc [$];
	logic exp_taken [$];
	blu_isa_pkg::xlen_t exp_target [$];

	int seed = 32'hf563_8759;
	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int result_num = 0;
	int cycles = 0;
	int cycle_limit = 1000;

	tb_clock i_clock (.CLK(CLK));

	blu_top i_dut (.*);

	function automatic logic outcome_taken(blu_isa_pkg::blu_op_t op, blu_isa_pkg::xlen_t a,
		blu_isa_pkg::xlen_t b);
		case (op)
			blu_isa_pkg::OP_BEQ:  return a == b;
			blu_isa_pkg::OP_BNE:  return a != b;
			blu_isa_pkg::OP_BLT:  return $signed(a) < $signed(b);
			blu_isa_pkg::OP_BGE:  return $signed(a) >= $signed(b);
			blu_isa_pkg::OP_BLTU: return a < b;
			blu_isa_pkg::OP_BGEU: return a >= b;
			default:              return 1'b1; // jal and jalr
		endcase
	endfunction

	task automatic add_write(blu_cfg_pkg::preg_t rd, blu_isa_pkg::xlen_t data);
		row_kind[row_count] = ROW_WR;
		row_rd[row_count] = rd;
		row_data[row_count] = data;
		model_reg[rd] = data;
		row_count++;
	endtask

	task automatic add_dispatch(int kind, blu_isa_pkg::blu_op_t op, blu_isa_pkg::xlen_t pc,
		blu_isa_pkg::xlen_t imm, blu_cfg_pkg::preg_t rd, blu_cfg_pkg::preg_t rs1,
		blu_cfg_pkg::preg_t rs2);
		blu_isa_pkg::xlen_t a;
		blu_isa_pkg::xlen_t b;
		a = (rs1 == 0) ? 64'd0 : model_reg[rs1];
		b = (rs2 == 0) ? 64'd0 : model_reg[rs2];
		row_kind[row_count] = kind;
		row_op[row_count] = op;
		row_pc[row_count] = pc;
		row_imm[row_count] = imm;
		row_rd[row_count] = rd;
		row_rs1[row_count] = rs1;
		row_rs2[row_count] = rs2;
		row_taken[row_count] = outcome_taken(op, a, b);
		if (!row_taken[row_count])
			row_target[row_count] = pc + 64'd4;
		else if (op == blu_isa_pkg::OP_JALR)
			row_target[row_count] = (a + imm) & ~64'd1;
		else
			row_target[row_count] = pc + imm;
		if (kind == ROW_DISP && (op == blu_isa_pkg::OP_JAL || op == blu_isa_pkg::OP_JALR))
			model_reg[rd] = pc + 64'd4; // Link value
		row_count++;
	endtask

	task automatic check_xlen(string name, blu_isa_pkg::xlen_t exp, blu_isa_pkg::xlen_t act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic close_test(string what, int errs_before);
		if (err_count == errs_before) begin
			pass_count++;
			$display("%s: ok", what);
		end else begin
			fail_count++;
			$display("%s: FAILED", what);
		end
	endtask

	task automatic build_table();
		blu_isa_pkg::xlen_t stall_val;
		for (int r = 0; r < blu_cfg_pkg::PREG_NUM; r++)
			model_reg[r] = 64'd0;
		add_write(1, 64'd5);
		add_write(2, 64'd5);
		add_write(3, -64'sd7); // Negative, large when unsigned
		add_write(4, 64'd9);
		add_write(5, {$random(seed), $random(seed)});
		add_write(6, {$random(seed), $random(seed)});
		add_write(7, 64'd0);
		add_write(9, 64'h3001);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BEQ, 64'h1000, 64'h20, 0, 1, 2);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BNE, 64'h1004, 64'h20, 0, 1, 2);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BLT, 64'h1008, -64'sd16, 0, 3, 4);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BLTU, 64'h100c, 64'h40, 0, 3, 4);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BGE, 64'h1010, 64'h40, 0, 3, 4);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BGEU, 64'h1014, 64'h40, 0, 3, 4);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BLT, 64'h1018, 64'h80, 0, 5, 6);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BGEU, 64'h101c, 64'h80, 0, 5, 6);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BEQ, 64'h1020, 64'h80, 0, 5, 5);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_JAL, 64'h2000, 64'h100, 10, 0, 0);
		add_write(8, 64'h2004);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BEQ, 64'h2100, 64'h40, 0, 10, 8);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_JALR, 64'h2104, 64'h10, 11, 9, 0);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BNE, 64'h2200, 64'h10, 0, 7, 0);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BLT, 64'h2204, 64'h10, 0, 0, 4);
		// Register 40 goes busy and stays so until the late external write
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BEQ, 64'h3000, 64'h8, 40, 1, 2);
		stall_val = {$random(seed), $random(seed)};
		model_reg[40] = stall_val;
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BLT, 64'h3100, 64'h30, 0, 40, 4);
		for (int i = 1; i < 8; i++)
			add_dispatch(ROW_DISP, (i % 2) ? blu_isa_pkg::OP_BLTU : blu_isa_pkg::OP_BNE,
				64'h3100 + 64'(4 * i), 64'h30, 0, 5, 6);
		add_dispatch(ROW_FULL, blu_isa_pkg::OP_BGE, 64'h3120, 64'h30, 0, 6, 5);
		add_write(40, stall_val);
		add_dispatch(ROW_DISP, blu_isa_pkg::OP_BGE, 64'h3120, 64'h30, 0, 6, 5);
	endtask

	task automatic apply_row(int i);
		int errs;
		dispatch_op = row_op[i];
		dispatch_pc = row_pc[i];
		dispatch_imm = row_imm[i];
		dispatch_rd = row_rd[i];
		dispatch_rs1 = row_rs1[i];
		dispatch_rs2 = row_rs2[i];
		if (row_kind[i] == ROW_WR) begin
			wb_valid = 1'b1;
			wb_rd = row_rd[i];
			wb_data = row_data[i];
			@(negedge CLK);
			wb_valid = 1'b0;
		end else if (row_kind[i] == ROW_FULL) begin
			errs = err_count;
			dispatch_valid = 1'b1;
			repeat (3) begin
				check_bit("dispatch_ready", 1'b0, dispatch_ready);
				@(negedge CLK);
			end
			dispatch_valid = 1'b0; // Withdrawn, no transfer took place
			close_test("back-pressure with full queue", errs);
		end else begin
			dispatch_valid = 1'b1;
			while (!dispatch_ready)
				@(negedge CLK);
			exp_pc.push_back(row_pc[i]);
			exp_taken.push_back(row_taken[i]);
			exp_target.push_back(row_target[i]);
			@(negedge CLK);
			dispatch_valid = 1'b0;
		end
	endtask

	// Results compared in dispatch order
	always @(negedge CLK) begin
		int errs;
		if (rst_n && res_valid) begin
			errs = err_count;
			result_num++;
			if (exp_pc.size() == 0) begin
				$display("result at %0t arrived with none expected", $time);
				err_count++;
			end else begin
				check_xlen("res_pc", exp_pc.pop_front(), res_pc);
				check_bit("res_taken", exp_taken.pop_front(), res_taken);
				check_xlen("res_target", exp_target.pop_front(), res_target);
			end
			close_test($sformatf("result %0d pc %h", result_num, res_pc), errs);
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d results never arrived", cycles,
				exp_pc.size());
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int errs;
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op = blu_isa_pkg::OP_BEQ;
		dispatch_pc = '0;
		dispatch_imm = '0;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		wb_valid = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		build_table();
		cycle_limit = row_count * 20 + 100;
		repeat (2) @(negedge CLK);
		rst_n = 1'b1;
		errs = err_count;
		check_bit("res_valid", 1'b0, res_valid);
		check_bit("dispatch_ready", 1'b1, dispatch_ready);
		close_test("reset state", errs);
		for (int i = 0; i < row_count; i++)
			apply_row(i);
		while (exp_pc.size() != 0)
			@(negedge CLK);
		repeat (5) @(negedge CLK); // Catch stray results
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
logic/blu_isa_pkg.sv
logic/blu_cfg_pkg.sv
logic/gen_buffer.sv
logic/blu_issue.sv
logic/reg_scoreboard.sv
logic/branch_resolve.sv
logic/blu_top.sv
testbench/tb_clock.sv
testbench/blu_tb.sv

// ==== Makefile ====
# Verilator build for the branch unit

VERILATOR ?= verilator
TOP       ?= blu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
